//--- hdl/addrPkg.sv
`default_nettype none

package addrPkg;

  localparam int sectionWidth = 5;
  localparam int offsetWidth  = 18;
  localparam int vmaWidth     = sectionWidth + offsetWidth;
  localparam int magicWidth   = 5;
  localparam int trapMixWidth = 4;
  localparam int diagWidth    = 24;

  // Offsets below this hit the fast AC block
  localparam int acLimit = 16;

  typedef logic [sectionWidth-1:0] section_t;
  typedef logic [offsetWidth-1:0]  offset_t;

  // Section in the high bits, offset in the low bits
  typedef logic [vmaWidth-1:0]     vmaAddr_t;

  typedef logic [magicWidth-1:0]   magic_t;
  typedef logic [trapMixWidth-1:0] trapMix_t;
  typedef logic [diagWidth-1:0]    diagWord_t;

  function automatic section_t sectionOf(input vmaAddr_t addr);
    return addr[vmaWidth-1:offsetWidth];
  endfunction

  function automatic offset_t offsetOf(input vmaAddr_t addr);
    return addr[offsetWidth-1:0];
  endfunction

endpackage

`default_nettype wire

//--- hdl/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

  // VMA offset source
  typedef enum logic [1:0] {
    SRC_AD       = 2'd0,
    SRC_PC_MAGIC = 2'd1,
    SRC_TRAP     = 2'd2,
    SRC_INC      = 2'd3
  } vmaSrc_e;

  // VMA section source
  typedef enum logic [1:0] {
    SECT_VMA  = 2'd0,
    SECT_PC   = 2'd1,
    SECT_PREV = 2'd2,
    SECT_AD   = 2'd3
  } sectSel_e;

  typedef enum logic [2:0] {
    DIAG_VMA    = 3'd0,
    DIAG_PC     = 3'd1,
    DIAG_HELD   = 3'd2,
    DIAG_ADRBRK = 3'd3,
    DIAG_FLAGS  = 3'd4
  } diagSel_e;

  typedef enum logic {
    IDLE = 1'b0,
    ACK  = 1'b1
  } diagState_e;

  // Bit positions in the flags readout word
  localparam int flagLocalAcBit = 5;
  localparam int flagMatchBit   = 6;
  localparam int flagSect0Bit   = 7;

endpackage

`default_nettype wire

//--- hdl/vmaAdder.sv
`timescale 1ns/1ps
`default_nettype none

module vmaAdder
  import addrPkg::*, ctrlPkg::*;
(
  input  vmaSrc_e  vmaSrc,
  input  vmaAddr_t ad,
  input  vmaAddr_t pc,
  input  vmaAddr_t vma,
  input  magic_t   magic,
  input  trapMix_t trapMix,
  output offset_t  nextOffset
);

  offset_t adOffset;
  offset_t pcOffset;
  offset_t vmaOffset;
  offset_t magicExt;
  offset_t pcPlusMagic;
  offset_t trapOffset;
  offset_t incOffset;

  assign adOffset  = offsetOf(ad);
  assign pcOffset  = offsetOf(pc);
  assign vmaOffset = offsetOf(vma);

  // Magic is an unsigned displacement into the low PC bits
  assign magicExt = offset_t'(magic);

  // Carry out of bit 18 is dropped so the sum stays in section
  assign pcPlusMagic = pcOffset + magicExt;

  // Trap vector replaces the low nibble of the PC
  assign trapOffset = {pcOffset[offsetWidth-1:trapMixWidth], trapMix};

  assign incOffset = vmaOffset + offset_t'(1);

  always_comb begin
    case (vmaSrc)
      SRC_AD: begin
        nextOffset = adOffset;
      end
      SRC_PC_MAGIC: begin
        nextOffset = pcPlusMagic;
      end
      SRC_TRAP: begin
        nextOffset = trapOffset;
      end
      SRC_INC: begin
        nextOffset = incOffset;
      end
      default: begin
        nextOffset = adOffset;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/sectionSelect.sv
`timescale 1ns/1ps
`default_nettype none

module sectionSelect
  import addrPkg::*, ctrlPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  sectSel_e sectSel,
  input  logic     loadPrevSec,
  input  vmaAddr_t ad,
  input  vmaAddr_t vma,
  input  vmaAddr_t pc,
  output section_t nextSection,
  output section_t prevSec
);

  // Previous context section, loaded from AD on a context switch
  always_ff @(posedge clk) begin
    if (reset) begin
      prevSec <= '0;
    end else if (loadPrevSec) begin
      prevSec <= sectionOf(ad);
    end
  end

  always_comb begin
    case (sectSel)
      SECT_VMA:  nextSection = sectionOf(vma);
      SECT_PC:   nextSection = sectionOf(pc);
      SECT_PREV: nextSection = prevSec;
      SECT_AD:   nextSection = sectionOf(ad);
      default:   nextSection = sectionOf(vma);
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/vmaRegs.sv
`timescale 1ns/1ps
`default_nettype none

module vmaRegs
  import addrPkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     loadVma,
  input  logic     loadPc,
  input  logic     loadHeld,
  input  logic     loadAdrBrk,
  input  logic     selHeld,
  input  logic     extended,
  input  logic     fetch,
  input  logic     readOrWrite,
  input  section_t nextSection,
  input  offset_t  nextOffset,
  input  vmaAddr_t ad,
  output vmaAddr_t vma,
  output vmaAddr_t pc,
  output vmaAddr_t held,
  output vmaAddr_t adrBrk,
  output vmaAddr_t heldOrPc,
  output logic     localAc,
  output logic     acRef,
  output logic     match
);

  section_t vmaSection;
  offset_t  vmaOffset;
  logic     lowSection;
  logic     acOffset;
  logic     localSpace;

  // All loads sample the old register values, so they can overlap
  always_ff @(posedge clk) begin
    if (reset) begin
      vma <= '0;
    end else if (loadVma) begin
      vma <= {nextSection, nextOffset};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (loadPc) begin
      pc <= vma;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      held <= '0;
    end else if (loadHeld) begin
      held <= vma;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      adrBrk <= '0;
    end else if (loadAdrBrk) begin
      adrBrk <= ad;
    end
  end

  assign vmaSection = sectionOf(vma);
  assign vmaOffset  = offsetOf(vma);

  // Sections 0 and 1 both see the ACs
  assign lowSection = vmaSection < section_t'(2);
  assign acOffset   = vmaOffset < offset_t'(acLimit);

  // Non-extended refs and instruction fetches are always local
  assign localSpace = lowSection | ~extended | fetch;

  assign localAc = acOffset & localSpace;
  assign acRef   = localAc & readOrWrite;

  assign match = vma == adrBrk;

  assign heldOrPc = selHeld ? held : pc;

endmodule

`default_nettype wire

//--- hdl/vmaDiag.sv
`timescale 1ns/1ps
`default_nettype none

module vmaDiag
  import addrPkg::*, ctrlPkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      diagReq,
  input  diagSel_e  diagSel,
  input  vmaAddr_t  vma,
  input  vmaAddr_t  pc,
  input  vmaAddr_t  held,
  input  vmaAddr_t  adrBrk,
  input  section_t  prevSec,
  input  logic      localAc,
  input  logic      match,
  output logic      diagAck,
  output diagWord_t diagData
);

  diagState_e state;
  diagWord_t  selWord;
  diagWord_t  flagWord;

  always_comb begin
    flagWord = '0;
    flagWord[sectionWidth-1:0] = prevSec;
    flagWord[flagLocalAcBit] = localAc;
    flagWord[flagMatchBit] = match;
    flagWord[flagSect0Bit] = sectionOf(vma) == '0;
  end

  always_comb begin
    case (diagSel)
      DIAG_VMA:    selWord = diagWord_t'(vma);
      DIAG_PC:     selWord = diagWord_t'(pc);
      DIAG_HELD:   selWord = diagWord_t'(held);
      DIAG_ADRBRK: selWord = diagWord_t'(adrBrk);
      DIAG_FLAGS:  selWord = flagWord;
      default:     selWord = '0;
    endcase
  end

  // Word is captured once on entry to ACK and held until the next request
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= IDLE;
      diagData <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (diagReq) begin
            diagData <= selWord;
            state    <= ACK;
          end
        end
        ACK: begin
          if (!diagReq) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign diagAck = state == ACK;

endmodule

`default_nettype wire

//--- hdl/vmaTop.sv
`timescale 1ns/1ps
`default_nettype none

module vmaTop
  import addrPkg::*, ctrlPkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  vmaAddr_t  ad,
  input  magic_t    magic,
  input  trapMix_t  trapMix,
  input  logic      loadVma,
  input  vmaSrc_e   vmaSrc,
  input  sectSel_e  sectSel,
  input  logic      loadPc,
  input  logic      loadHeld,
  input  logic      loadAdrBrk,
  input  logic      loadPrevSec,
  input  logic      extended,
  input  logic      fetch,
  input  logic      readOrWrite,
  input  logic      selHeld,
  input  logic      diagReq,
  input  diagSel_e  diagSel,
  output vmaAddr_t  vma,
  output vmaAddr_t  heldOrPc,
  output logic      acRef,
  output logic      localAc,
  output logic      match,
  output logic      diagAck,
  output diagWord_t diagData
);

  offset_t  nextOffset;
  section_t nextSection;
  section_t prevSec;
  vmaAddr_t pc;
  vmaAddr_t held;
  vmaAddr_t adrBrk;

  vmaAdder u_adder (
    .vmaSrc     (vmaSrc),
    .ad         (ad),
    .pc         (pc),
    .vma        (vma),
    .magic      (magic),
    .trapMix    (trapMix),
    .nextOffset (nextOffset)
  );

  sectionSelect u_section (
    .clk         (clk),
    .reset       (reset),
    .sectSel     (sectSel),
    .loadPrevSec (loadPrevSec),
    .ad          (ad),
    .vma         (vma),
    .pc          (pc),
    .nextSection (nextSection),
    .prevSec     (prevSec)
  );

  vmaRegs u_regs (
    .clk         (clk),
    .reset       (reset),
    .loadVma     (loadVma),
    .loadPc      (loadPc),
    .loadHeld    (loadHeld),
    .loadAdrBrk  (loadAdrBrk),
    .selHeld     (selHeld),
    .extended    (extended),
    .fetch       (fetch),
    .readOrWrite (readOrWrite),
    .nextSection (nextSection),
    .nextOffset  (nextOffset),
    .ad          (ad),
    .vma         (vma),
    .pc          (pc),
    .held        (held),
    .adrBrk      (adrBrk),
    .heldOrPc    (heldOrPc),
    .localAc     (localAc),
    .acRef       (acRef),
    .match       (match)
  );

  vmaDiag u_diag (
    .clk      (clk),
    .reset    (reset),
    .diagReq  (diagReq),
    .diagSel  (diagSel),
    .vma      (vma),
    .pc       (pc),
    .held     (held),
    .adrBrk   (adrBrk),
    .prevSec  (prevSec),
    .localAc  (localAc),
    .match    (match),
    .diagAck  (diagAck),
    .diagData (diagData)
  );

endmodule

`default_nettype wire

//--- tests/vma_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module vmaDiagAssertions
  import addrPkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      diagReq,
  input logic      diagAck,
  input diagWord_t diagData
);

  int failCount = 0;

  // Ack only answers a request
  ackAfterReq: assert property (@(posedge clk) disable iff (reset)
    $rose(diagAck) |-> $past(diagReq))
    else begin
      failCount++;
      $error("diagAck rose without diagReq");
    end

  dataHeld: assert property (@(posedge clk) disable iff (reset)
    diagAck && $past(diagAck) |-> $stable(diagData))
    else begin
      failCount++;
      $error("diagData changed while diagAck was high");
    end

  ackDropAfterReqLow: assert property (@(posedge clk) disable iff (reset)
    $fell(diagAck) |-> !$past(diagReq))
    else begin
      failCount++;
      $error("diagAck fell while diagReq was still high");
    end

  resetClears: assert property (@(posedge clk)
    reset |=> !diagAck && diagData == '0)
    else begin
      failCount++;
      $error("diagnostic port not cleared by reset");
    end

endmodule

bind vmaDiag vmaDiagAssertions u_diagChecks (
  .clk      (clk),
  .reset    (reset),
  .diagReq  (diagReq),
  .diagAck  (diagAck),
  .diagData (diagData)
);

`default_nettype wire

//--- tests/vmaTb.sv
`timescale 1ns/1ps
`default_nettype none

module vmaTb
  import addrPkg::*, ctrlPkg::*;
();

  localparam int numPatterns  = 20;
  localparam int wordsPerLine = 9;
  localparam int resetCycles  = 16;
  localparam int ackTimeout   = 4;

  logic      clk;
  logic      reset;
  vmaAddr_t  ad;
  magic_t    magic;
  trapMix_t  trapMix;
  logic      loadVma;
  vmaSrc_e   vmaSrc;
  sectSel_e  sectSel;
  logic      loadPc;
  logic      loadHeld;
  logic      loadAdrBrk;
  logic      loadPrevSec;
  logic      extended;
  logic      fetch;
  logic      readOrWrite;
  logic      selHeld;
  logic      diagReq;
  diagSel_e  diagSel;
  vmaAddr_t  vma;
  vmaAddr_t  heldOrPc;
  logic      acRef;
  logic      localAc;
  logic      match;
  logic      diagAck;
  diagWord_t diagData;

  logic [63:0] patMem [numPatterns*wordsPerLine];
  logic [31:0] lfsrState;

  vmaTop u_dut (
    .clk         (clk),
    .reset       (reset),
    .ad          (ad),
    .magic       (magic),
    .trapMix     (trapMix),
    .loadVma     (loadVma),
    .vmaSrc      (vmaSrc),
    .sectSel     (sectSel),
    .loadPc      (loadPc),
    .loadHeld    (loadHeld),
    .loadAdrBrk  (loadAdrBrk),
    .loadPrevSec (loadPrevSec),
    .extended    (extended),
    .fetch       (fetch),
    .readOrWrite (readOrWrite),
    .selHeld     (selHeld),
    .diagReq     (diagReq),
    .diagSel     (diagSel),
    .vma         (vma),
    .heldOrPc    (heldOrPc),
    .acRef       (acRef),
    .localAc     (localAc),
    .match       (match),
    .diagAck     (diagAck),
    .diagData    (diagData)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stopRun(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Run stopped on error");
  endtask

  task automatic checkAddr(input string what, input vmaAddr_t actual, input vmaAddr_t expected);
    if (actual !== expected) begin
      stopRun($sformatf("[FAIL] time %0d ns: %s is %h, expected %h",
                        $time, what, actual, expected));
    end
  endtask

  task automatic checkFlag(input string what, input logic actual, input logic expected);
    if (actual !== expected) begin
      stopRun($sformatf("[FAIL] time %0d ns: %s is %b, expected %b",
                        $time, what, actual, expected));
    end
  endtask

  task automatic checkDiag(input string what, input diagWord_t actual,
                           input diagWord_t expected);
    if (actual !== expected) begin
      stopRun($sformatf("[FAIL] time %0d ns: %s is %h, expected %h",
                        $time, what, actual, expected));
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] nextLfsr(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  task automatic takeRandom(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++) begin
      lfsrState = nextLfsr(lfsrState);
      value = (value << 1) | int'(lfsrState[0]);
    end
  endtask

  // Control word holds one field per hex digit
  task automatic applyLine(input int base);
    logic [63:0] ctrl;
    ctrl        = patMem[base + 3];
    ad          = vmaAddr_t'(patMem[base]);
    magic       = magic_t'(patMem[base + 1]);
    trapMix     = trapMix_t'(patMem[base + 2]);
    loadVma     = ctrl[40];
    vmaSrc      = vmaSrc_e'(ctrl[37:36]);
    sectSel     = sectSel_e'(ctrl[33:32]);
    loadPc      = ctrl[28];
    loadHeld    = ctrl[24];
    loadAdrBrk  = ctrl[20];
    loadPrevSec = ctrl[16];
    extended    = ctrl[12];
    fetch       = ctrl[8];
    readOrWrite = ctrl[4];
    selHeld     = ctrl[0];
    diagReq     = 1'b0;
  endtask

  task automatic checkLine(input int idx, input int base);
    logic [63:0] flags;
    flags = patMem[base + 7];
    checkAddr($sformatf("vma, pattern %0d", idx + 1), vma, vmaAddr_t'(patMem[base + 5]));
    checkAddr($sformatf("heldOrPc, pattern %0d", idx + 1), heldOrPc,
              vmaAddr_t'(patMem[base + 6]));
    checkFlag($sformatf("acRef, pattern %0d", idx + 1), acRef, flags[8]);
    checkFlag($sformatf("localAc, pattern %0d", idx + 1), localAc, flags[4]);
    checkFlag($sformatf("match, pattern %0d", idx + 1), match, flags[0]);
    if (u_dut.u_diag.u_diagChecks.failCount != 0) begin
      stopRun("A handshake assertion on the diagnostic port failed");
    end
  endtask

  task automatic readDiag(input diagSel_e sel, input diagWord_t expected);
    int waited;
    int holdCycles;
    loadVma     = 1'b0;
    loadPc      = 1'b0;
    loadHeld    = 1'b0;
    loadAdrBrk  = 1'b0;
    loadPrevSec = 1'b0;
    diagSel     = sel;
    diagReq     = 1'b1;
    waited      = 0;
    @(negedge clk);
    while (diagAck !== 1'b1) begin
      if (waited == ackTimeout) begin
        stopRun("diagAck never rose after diagReq was raised");
      end
      waited++;
      @(negedge clk);
    end
    checkDiag($sformatf("diagData for %s", sel.name()), diagData, expected);
    // Master holds the request a random while
    takeRandom(3, holdCycles);
    repeat (holdCycles) @(negedge clk);
    diagReq = 1'b0;
    waited  = 0;
    @(negedge clk);
    while (diagAck !== 1'b0) begin
      if (waited == ackTimeout) begin
        stopRun("diagAck stayed high after diagReq was dropped");
      end
      waited++;
      @(negedge clk);
    end
  endtask

  initial begin
    int base;
    logic [63:0] diagWord;
    reset     = 1'b1;
    lfsrState = 32'h6f37_a2a9;
    diagSel   = DIAG_VMA;
    $readmemh("tests/vma_patterns.hex", patMem);
    applyLine(0);
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    checkFlag("diagAck after reset", diagAck, 1'b0);
    checkDiag("diagData after reset", diagData, '0);
    for (int idx = 0; idx < numPatterns; idx++) begin
      base = idx * wordsPerLine;
      applyLine(base);
      @(posedge clk);
      @(negedge clk);
      checkLine(idx, base);
      diagWord = patMem[base + 4];
      if (diagWord[4]) begin
        readDiag(diagSel_e'(diagWord[2:0]), diagWord_t'(patMem[base + 8]));
      end
    end
    if (u_dut.u_diag.u_diagChecks.failCount != 0) begin
      stopRun("A handshake assertion on the diagnostic port failed");
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

  initial begin
    repeat (numPatterns * 20 + resetCycles) @(posedge clk);
    stopRun("Watchdog expired before all patterns were run");
  end

endmodule

`default_nettype wire

//--- tests/vma_patterns.hex
// ad magic trapMix ctrl diag expVma expHeldOrPc expFlags expDiag
// ctrl digits: loadVma vmaSrc sectSel loadPc loadHeld loadAdrBrk loadPrevSec ext fetch rw selHeld
// diag: request then selector; expFlags digits: acRef localAc match
000000 00 0 00000000000 00 000000 000000 011 000000
000000 00 0 00000000010 00 000000 000000 111 000000
0C0123 00 0 00000100000 00 000000 000000 010 000000
0C0123 00 0 10300000000 00 0C0123 000000 001 000000
1C0010 00 0 13010010000 00 0C0124 0C0123 000 000000
0BFFFE 00 0 10301000001 00 0BFFFE 0C0124 000 000000
000000 00 0 13010000000 00 0BFFFF 0BFFFE 000 000000
000000 00 0 13000001010 00 080000 0BFFFE 000 000000
000000 00 0 00000001110 00 080000 0BFFFE 110 000000
000000 05 0 11100001010 00 080003 0BFFFE 000 000000
000000 00 9 12200000000 00 1FFFF9 0BFFFE 000 000000
000005 00 0 10000000010 00 1C0005 0BFFFE 110 000000
000005 00 0 00000001010 00 1C0005 0BFFFE 000 000000
04000F 00 0 10300101010 00 04000F 0BFFFE 111 000000
000000 00 0 13001001011 00 040010 04000F 000 000000
000000 00 0 00000001011 10 040010 04000F 000 040010
000000 00 0 00000001011 11 040010 04000F 000 0BFFFE
000000 00 0 00000001011 12 040010 04000F 000 04000F
000000 00 0 00000001011 13 040010 04000F 000 04000F
000003 00 0 10300101000 14 000003 0BFFFE 011 0000E7

//--- sources.f
hdl/addrPkg.sv
hdl/ctrlPkg.sv
hdl/vmaAdder.sv
hdl/sectionSelect.sv
hdl/vmaRegs.sv
hdl/vmaDiag.sv
hdl/vmaTop.sv
tests/vma_assertions.sv
tests/vmaTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module vmaTb -f sources.f -Mdir obj_dir
./obj_dir/VvmaTb +verilator+error+limit+100
